// ==== regx_consts.svh ====
`ifndef REGX_CONSTS_SVH
`define REGX_CONSTS_SVH

// ==========================================================
// Register block constants
// ==========================================================

// Read value of any slot with no register behind it
`define REGX_UNIMPL_RD 8'hFF

// Extra equal samples before a debounced bit flips
`define REGX_DBNC_LEN 2

// NVMCTL reset value, only bits 7:2 are stored
`define REGX_NVM_RST 8'h08

// ==========================================================
// Magic codes
// ==========================================================

`define REGX_WAKE_CLR 8'hC1 // WAKE write data that clears the latch

`endif

// ==== regx_pkg.sv ====
package regx_pkg;

   // ==========================================================
   // Command bus opcodes
   // ==========================================================
   typedef enum logic [1:0] {
      XOP_IDLE  = 2'd0,
      XOP_READ  = 2'd1,
      XOP_WRITE = 2'd2
   } xbus_op_e;

   // ==========================================================
   // Slot offsets inside the 0x80..0xFF window
   // ==========================================================
   typedef enum logic [6:0] {
      RA_PWM0   = 7'h00, // PWM compare, shadowed
      RA_PWM1   = 7'h01, // PWM period, shadowed
      RA_BCK0   = 7'h04,
      RA_BCK1   = 7'h05,
      RA_DMY0   = 7'h07,
      RA_NVMCTL = 7'h12,
      RA_STAT   = 7'h14, // Debounced inputs
      RA_WAKE   = 7'h16, // Async wake latch
      RA_BPPCL  = 7'h18,
      RA_BPPCH  = 7'h19  // Commits the breakpoint
   } regx_addr_e;

endpackage

// ==== dbnc.sv ====
`timescale 1ns/100ps
`include "regx_consts.svh"

module dbnc (
   input  logic clk,
   input  logic aswk_clrz,
   input  logic i_org,
   output logic o_dbc,
   output logic o_chg
);

   localparam int CNT_W = $clog2(`REGX_DBNC_LEN + 1);

   logic             sync_1;
   logic             sync_2;
   logic [CNT_W-1:0] cnt;

   // Two-flop synchroniser for the raw input
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         sync_1 <= 1'b0;
         sync_2 <= 1'b0;
      end else begin
         sync_1 <= i_org;
         sync_2 <= sync_1;
      end
   end

   // Count consecutive samples that disagree with o_dbc
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         cnt   <= '0;
         o_dbc <= 1'b0;
         o_chg <= 1'b0;
      end else begin
         o_chg <= 1'b0;
         if (sync_2 == o_dbc) begin
            cnt <= '0; // Glitch gone, start over
         end else if (cnt == CNT_W'(`REGX_DBNC_LEN)) begin
            cnt   <= '0;
            o_dbc <= sync_2;
            o_chg <= 1'b1; // One-cycle change flag
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

// ==== xdata_dec.sv ====
`timescale 1ns/100ps

module xdata_dec (
   input  logic                 clk,
   input  logic                 aswk_clrz,
   input  logic                 i_cmd_stb,
   input  regx_pkg::xbus_op_e   i_cmd_op,
   input  logic [7:0]           i_cmd_addr,
   input  logic [7:0]           i_cmd_wdat,
   input  logic [7:0]           i_rdat,
   output logic                 o_rd_stb,
   output logic                 o_wr_stb,
   output logic [6:0]           o_addr,
   output logic [7:0]           o_wdat,
   output logic                 o_rsp_stb,
   output logic [7:0]           o_rsp_rdat,
   output logic                 o_rsp_miss
);

   logic cmd_hit;
   logic cmd_rd;
   logic cmd_wr;
   logic tok_1; // Response due, stage 1
   logic miss_1;
   logic tok_2; // Response due, stage 2
   logic miss_2;

   assign cmd_hit = i_cmd_addr[7]; // Window 0x80..0xFF
   assign cmd_rd  = i_cmd_stb && (i_cmd_op == regx_pkg::XOP_READ);
   assign cmd_wr  = i_cmd_stb && (i_cmd_op == regx_pkg::XOP_WRITE);

   // ==========================================================
   // Command register and read token pipeline
   // ==========================================================
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         o_rd_stb   <= 1'b0;
         o_wr_stb   <= 1'b0;
         tok_1      <= 1'b0;
         miss_1     <= 1'b0;
         tok_2      <= 1'b0;
         miss_2     <= 1'b0;
         o_rsp_stb  <= 1'b0;
         o_rsp_miss <= 1'b0;
         o_rsp_rdat <= 8'h00;
      end else begin
         o_rd_stb   <= cmd_rd && cmd_hit;
         o_wr_stb   <= cmd_wr && cmd_hit; // Missed writes are dropped
         tok_1      <= cmd_rd;
         miss_1     <= cmd_rd && !cmd_hit;
         tok_2      <= tok_1;
         miss_2     <= miss_1;
         o_rsp_stb  <= tok_2;
         o_rsp_miss <= tok_2 && miss_2;
         if (tok_2) begin
            o_rsp_rdat <= miss_2 ? 8'h00 : i_rdat;
         end
      end
   end

   // Address and data only qualify the strobes
   always_ff @(posedge clk) begin
      if (i_cmd_stb) begin
         o_addr <= i_cmd_addr[6:0];
         o_wdat <= i_cmd_wdat;
      end
   end

endmodule

// ==== regx.sv ====
`timescale 1ns/100ps
`include "regx_consts.svh"

module regx (
   input  logic        clk,
   input  logic        aswk_clrz,
   input  logic        i_rd_stb,
   input  logic        i_wr_stb,
   input  logic [6:0]  i_addr,
   input  logic [7:0]  i_wdat,
   input  logic [15:0] i_pwm_set,
   input  logic [3:0]  i_di_stat,
   input  logic        i_aswclk,
   input  logic [4:0]  i_di_aswk,
   output logic [7:0]  o_rdat,
   output logic        o_pwm_wr_lo,
   output logic        o_pwm_wr_hi,
   output logic [7:0]  o_bck0,
   output logic [7:0]  o_bck1,
   output logic [7:0]  o_dmy0,
   output logic [5:0]  o_nvm_ctl,
   output logic [14:0] o_bkpt_pc,
   output logic        o_bkpt_ena
);

   localparam logic [7:0] NVM_RST_VAL = `REGX_NVM_RST;

   logic [6:0] rd_addr;     // Address held for the read mux
   logic [7:0] bck0;
   logic [7:0] bck1;
   logic [7:0] dmy0;
   logic [5:0] nvm_ctl;     // NVMCTL bits 7:2
   logic [3:0] stat_db;
   logic       wake_clr_wr;
   logic       wake_clr_q;
   logic       wake_clrz;
   logic [5:0] lt_aswk;     // Flag plus captured bits
   logic [5:0] wake_s1;
   logic [5:0] wake_s2;
   logic [7:0] bp_tmp;
   logic [7:0] bp_lo;
   logic [7:0] bp_hi;

   // ==========================================================
   // Write decode
   // ==========================================================
   function automatic logic wr_hit(input regx_pkg::regx_addr_e slot);
      return i_wr_stb && (i_addr == slot);
   endfunction

   assign o_pwm_wr_lo = wr_hit(regx_pkg::RA_PWM0); // Shadow strobes to the PWM block
   assign o_pwm_wr_hi = wr_hit(regx_pkg::RA_PWM1);
   assign wake_clr_wr = wr_hit(regx_pkg::RA_WAKE) && (i_wdat == `REGX_WAKE_CLR);

   // ==========================================================
   // Local read/write registers
   // ==========================================================
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         bck0    <= 8'h00;
         bck1    <= 8'h00;
         dmy0    <= 8'h00;
         nvm_ctl <= NVM_RST_VAL[7:2];
      end else begin
         if (wr_hit(regx_pkg::RA_BCK0)) bck0 <= i_wdat;
         if (wr_hit(regx_pkg::RA_BCK1)) bck1 <= i_wdat;
         if (wr_hit(regx_pkg::RA_DMY0)) dmy0 <= i_wdat;
         if (wr_hit(regx_pkg::RA_NVMCTL)) nvm_ctl <= i_wdat[7:2];
      end
   end

   assign o_bck0    = bck0;
   assign o_bck1    = bck1;
   assign o_dmy0    = dmy0;
   assign o_nvm_ctl = nvm_ctl;

   // ==========================================================
   // Breakpoint, low byte waits in bp_tmp until BPPCH
   // ==========================================================
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         bp_tmp <= 8'h00;
         bp_lo  <= 8'h00;
         bp_hi  <= 8'h00;
      end else begin
         if (wr_hit(regx_pkg::RA_BPPCL)) bp_tmp <= i_wdat;
         if (wr_hit(regx_pkg::RA_BPPCH)) begin
            bp_lo <= bp_tmp; // Both bytes commit together
            bp_hi <= i_wdat;
         end
      end
   end

   assign o_bkpt_pc  = {bp_hi[6:0], bp_lo};
   assign o_bkpt_ena = bp_hi[7];

   // ==========================================================
   // Debounced status inputs
   // ==========================================================
   for (genvar i = 0; i < 4; i++) begin : g_stat
      dbnc u_dbnc (
         .clk       (clk),
         .aswk_clrz (aswk_clrz),
         .i_org     (i_di_stat[i]),
         .o_dbc     (stat_db[i]),
         .o_chg     ()
      );
   end

   // ==========================================================
   // Wake latch on i_aswclk
   // ==========================================================
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         wake_clr_q <= 1'b0;
      end else begin
         wake_clr_q <= wake_clr_wr;
      end
   end

   assign wake_clrz = aswk_clrz & ~wake_clr_q; // Global or magic-write clear

   always_ff @(posedge i_aswclk or negedge wake_clrz) begin
      if (!wake_clrz) begin
         lt_aswk <= 6'h00;
      end else begin
         lt_aswk <= {1'b1, i_di_aswk};
      end
   end

   // Bring the latch into clk, flushed by the clear write
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         wake_s1 <= 6'h00;
         wake_s2 <= 6'h00;
      end else if (wake_clr_wr) begin
         wake_s1 <= 6'h00;
         wake_s2 <= 6'h00;
      end else begin
         wake_s1 <= lt_aswk;
         wake_s2 <= wake_s1;
      end
   end

   // ==========================================================
   // Read path
   // ==========================================================
   always_ff @(posedge clk) begin
      if (i_rd_stb) rd_addr <= i_addr;
   end

   always_comb begin
      case (rd_addr)
         regx_pkg::RA_PWM0:   o_rdat = i_pwm_set[7:0];
         regx_pkg::RA_PWM1:   o_rdat = i_pwm_set[15:8];
         regx_pkg::RA_BCK0:   o_rdat = bck0;
         regx_pkg::RA_BCK1:   o_rdat = bck1;
         regx_pkg::RA_DMY0:   o_rdat = dmy0;
         regx_pkg::RA_NVMCTL: o_rdat = {nvm_ctl, 2'b00};
         regx_pkg::RA_STAT:   o_rdat = {4'h0, stat_db};
         regx_pkg::RA_WAKE:   o_rdat = {2'b00, wake_s2};
         regx_pkg::RA_BPPCL:  o_rdat = bp_lo; // Committed byte, not bp_tmp
         regx_pkg::RA_BPPCH:  o_rdat = bp_hi;
         default:             o_rdat = `REGX_UNIMPL_RD;
      endcase
   end

endmodule

// ==== pwm_gen.sv ====
`timescale 1ns/100ps

module pwm_gen (
   input  logic        clk,
   input  logic        aswk_clrz,
   input  logic        i_wr_lo,
   input  logic        i_wr_hi,
   input  logic [7:0]  i_wdat,
   output logic [15:0] o_pwm_set,
   output logic        o_pwm
);

   logic [7:0] pwm_cmp; // High time in clocks
   logic [7:0] pwm_per; // Last counter value of a cycle
   logic [7:0] cnt;

   // ==========================================================
   // Setting registers and period counter
   // ==========================================================
   always_ff @(posedge clk or negedge aswk_clrz) begin
      if (!aswk_clrz) begin
         pwm_cmp <= 8'h00;
         pwm_per <= 8'h00;
         cnt     <= 8'h00;
         o_pwm   <= 1'b0;
      end else begin
         if (i_wr_lo) pwm_cmp <= i_wdat;
         if (i_wr_hi) pwm_per <= i_wdat;

         if (i_wr_lo || i_wr_hi) begin
            cnt <= 8'h00; // New setting restarts the cycle
         end else if (cnt >= pwm_per) begin
            cnt <= 8'h00;
         end else begin
            cnt <= cnt + 8'h01;
         end

         o_pwm <= (cnt < pwm_cmp);
      end
   end

   assign o_pwm_set = {pwm_per, pwm_cmp}; // Shadow value read back by the bank

endmodule

// ==== regx_top.sv ====
`timescale 1ns/100ps

module regx_top (
   input  logic               clk,
   input  logic               aswk_clrz,
   input  logic               i_cmd_stb,
   input  regx_pkg::xbus_op_e i_cmd_op,
   input  logic [7:0]         i_cmd_addr,
   input  logic [7:0]         i_cmd_wdat,
   output logic               o_rsp_stb,
   output logic [7:0]         o_rsp_rdat,
   output logic               o_rsp_miss,
   input  logic [3:0]         i_di_stat,
   input  logic               i_aswclk,
   input  logic [4:0]         i_di_aswk,
   output logic               o_pwm,
   output logic [7:0]         o_bck0,
   output logic [7:0]         o_bck1,
   output logic [7:0]         o_dmy0,
   output logic [5:0]         o_nvm_ctl,
   output logic [14:0]        o_bkpt_pc,
   output logic               o_bkpt_ena
);

   logic        rd_stb;
   logic        wr_stb;
   logic [6:0]  addr;
   logic [7:0]  wdat;
   logic [7:0]  rdat;
   logic        pwm_wr_lo;
   logic        pwm_wr_hi;
   logic [15:0] pwm_set;

   // ==========================================================
   // Command front end
   // ==========================================================
   xdata_dec u_xdata_dec (
      .clk        (clk),
      .aswk_clrz  (aswk_clrz),
      .i_cmd_stb  (i_cmd_stb),
      .i_cmd_op   (i_cmd_op),
      .i_cmd_addr (i_cmd_addr),
      .i_cmd_wdat (i_cmd_wdat),
      .i_rdat     (rdat),
      .o_rd_stb   (rd_stb),
      .o_wr_stb   (wr_stb),
      .o_addr     (addr),
      .o_wdat     (wdat),
      .o_rsp_stb  (o_rsp_stb),
      .o_rsp_rdat (o_rsp_rdat),
      .o_rsp_miss (o_rsp_miss)
   );

   // ==========================================================
   // Register bank
   // ==========================================================
   regx u_regx (
      .clk         (clk),
      .aswk_clrz   (aswk_clrz),
      .i_rd_stb    (rd_stb),
      .i_wr_stb    (wr_stb),
      .i_addr      (addr),
      .i_wdat      (wdat),
      .i_pwm_set   (pwm_set),
      .i_di_stat   (i_di_stat),
      .i_aswclk    (i_aswclk),
      .i_di_aswk   (i_di_aswk),
      .o_rdat      (rdat),
      .o_pwm_wr_lo (pwm_wr_lo),
      .o_pwm_wr_hi (pwm_wr_hi),
      .o_bck0      (o_bck0),
      .o_bck1      (o_bck1),
      .o_dmy0      (o_dmy0),
      .o_nvm_ctl   (o_nvm_ctl),
      .o_bkpt_pc   (o_bkpt_pc),
      .o_bkpt_ena  (o_bkpt_ena)
   );

   // PWM block, write data shared with the bank
   pwm_gen u_pwm_gen (
      .clk       (clk),
      .aswk_clrz (aswk_clrz),
      .i_wr_lo   (pwm_wr_lo),
      .i_wr_hi   (pwm_wr_hi),
      .i_wdat    (wdat),
      .o_pwm_set (pwm_set),
      .o_pwm     (o_pwm)
   );

endmodule

// ==== tb_regx_top.sv ====
`timescale 1ns/100ps
`include "regx_consts.svh"

module tb_regx_top;

   localparam logic [7:0] NVM_RST = `REGX_NVM_RST;

   logic               clk;
   logic               aswk_clrz;
   logic               i_cmd_stb;
   regx_pkg::xbus_op_e i_cmd_op;
   logic [7:0]         i_cmd_addr;
   logic [7:0]         i_cmd_wdat;
   logic               o_rsp_stb;
   logic [7:0]         o_rsp_rdat;
   logic               o_rsp_miss;
   logic [3:0]         i_di_stat;
   logic               i_aswclk;
   logic [4:0]         i_di_aswk;
   logic               o_pwm;
   logic [7:0]         o_bck0;
   logic [7:0]         o_bck1;
   logic [7:0]         o_dmy0;
   logic [5:0]         o_nvm_ctl;
   logic [14:0]        o_bkpt_pc;
   logic               o_bkpt_ena;
   int                 seed;

   // ==========================================================
   // Command table applied one entry per clock
   // ==========================================================
   regx_pkg::xbus_op_e tbl_op[$];
   logic [7:0]         tbl_addr[$];
   logic [7:0]         tbl_wdat[$];
   logic [7:0]         tbl_exp[$];
   logic               tbl_miss[$];
   int                 due_q[$]; // Cycle a pending response is due
   int                 idx_q[$]; // Table entry of that response

   regx_top regx_top_inst (
      .clk        (clk),
      .aswk_clrz  (aswk_clrz),
      .i_cmd_stb  (i_cmd_stb),
      .i_cmd_op   (i_cmd_op),
      .i_cmd_addr (i_cmd_addr),
      .i_cmd_wdat (i_cmd_wdat),
      .o_rsp_stb  (o_rsp_stb),
      .o_rsp_rdat (o_rsp_rdat),
      .o_rsp_miss (o_rsp_miss),
      .i_di_stat  (i_di_stat),
      .i_aswclk   (i_aswclk),
      .i_di_aswk  (i_di_aswk),
      .o_pwm      (o_pwm),
      .o_bck0     (o_bck0),
      .o_bck1     (o_bck1),
      .o_dmy0     (o_dmy0),
      .o_nvm_ctl  (o_nvm_ctl),
      .o_bkpt_pc  (o_bkpt_pc),
      .o_bkpt_ena (o_bkpt_ena)
   );

   always #10 clk = ~clk;

   // ==========================================================
   // Compare and stop helpers
   // ==========================================================
   task automatic stop_on_error();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic timeout_stop(input string what);
      $display("Timed out waiting for %s", what);
      stop_on_error();
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("FAIL @%0t ns: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL @%0t ns: %s, got %b, expected %b", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_pc(input string what, input logic [14:0] got, input logic [14:0] exp);
      if (got !== exp) begin
         $display("FAIL @%0t ns: %s, got 0x%04h, expected 0x%04h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   function automatic logic [7:0] rand_byte();
      int r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic logic [7:0] slot_addr(input regx_pkg::regx_addr_e ra);
      return {1'b1, ra}; // Window starts at 0x80
   endfunction

   // ==========================================================
   // Table building and playback
   // ==========================================================
   task automatic clear_table();
      tbl_op.delete();
      tbl_addr.delete();
      tbl_wdat.delete();
      tbl_exp.delete();
      tbl_miss.delete();
   endtask

   task automatic add_entry(input regx_pkg::xbus_op_e op, input logic [7:0] addr,
                            input logic [7:0] wdat, input logic [7:0] exp, input logic miss);
      tbl_op.push_back(op);
      tbl_addr.push_back(addr);
      tbl_wdat.push_back(wdat);
      tbl_exp.push_back(exp);
      tbl_miss.push_back(miss);
   endtask

   task automatic add_rd(input logic [7:0] addr, input logic [7:0] exp, input logic miss);
      add_entry(regx_pkg::XOP_READ, addr, 8'h00, exp, miss);
   endtask

   task automatic add_wr(input logic [7:0] addr, input logic [7:0] wdat);
      add_entry(regx_pkg::XOP_WRITE, addr, wdat, 8'h00, 1'b0);
   endtask

   task automatic idle_cmd();
      i_cmd_stb = 1'b0;
      i_cmd_op  = regx_pkg::XOP_IDLE;
   endtask

   // Response must show up exactly two edges after the sampling edge
   task automatic collect_rsp(input int cyc);
      logic due;
      int   idx;
      due = 1'b0;
      if (due_q.size() > 0) begin
         due = (due_q[0] == cyc);
      end
      check_bit("response strobe", o_rsp_stb, due);
      if (due) begin
         idx = idx_q.pop_front();
         void'(due_q.pop_front());
         check_byte($sformatf("read data at 0x%02h", tbl_addr[idx]), o_rsp_rdat, tbl_exp[idx]);
         check_bit($sformatf("miss flag at 0x%02h", tbl_addr[idx]), o_rsp_miss, tbl_miss[idx]);
      end
   endtask

   task automatic run_table();
      int cyc;
      int guard;
      cyc = 0;
      for (int i = 0; i < tbl_op.size(); i++) begin
         i_cmd_stb  = 1'b1;
         i_cmd_op   = tbl_op[i];
         i_cmd_addr = tbl_addr[i];
         i_cmd_wdat = tbl_wdat[i];
         if (tbl_op[i] == regx_pkg::XOP_READ) begin
            due_q.push_back(cyc + 3);
            idx_q.push_back(i);
         end
         @(posedge clk);
         #1;
         cyc++;
         collect_rsp(cyc);
      end
      idle_cmd();
      guard = 0;
      while (guard < 8 && (due_q.size() > 0 || guard < 2)) begin
         @(posedge clk);
         #1;
         cyc++;
         guard++;
         collect_rsp(cyc);
      end
      if (due_q.size() > 0) timeout_stop("read responses");
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      int n;
      i_cmd_stb  = 1'b1;
      i_cmd_op   = regx_pkg::XOP_READ;
      i_cmd_addr = addr;
      @(posedge clk);
      #1;
      idle_cmd();
      n = 1;
      while (!o_rsp_stb && n < 8) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!o_rsp_stb) timeout_stop("single read response");
      data = o_rsp_rdat;
   endtask

   // ==========================================================
   // PWM and debounce checks
   // ==========================================================
   task automatic check_pwm(input logic [7:0] cmp, input logic [7:0] per);
      int hi_cnt;
      int exp_cnt;
      clear_table();
      add_wr(slot_addr(regx_pkg::RA_PWM0), cmp);
      add_wr(slot_addr(regx_pkg::RA_PWM1), per);
      add_rd(slot_addr(regx_pkg::RA_PWM0), cmp, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_PWM1), per, 1'b0);
      run_table();
      exp_cnt = (int'(cmp) < int'(per) + 1) ? int'(cmp) : int'(per) + 1;
      hi_cnt  = 0;
      for (int n = 0; n <= int'(per); n++) begin // One full PWM cycle
         if (o_pwm) hi_cnt++;
         @(posedge clk);
         #1;
      end
      check_byte($sformatf("PWM high clocks, cmp %0d per %0d", cmp, per),
                 hi_cnt[7:0], exp_cnt[7:0]);
   endtask

   task automatic wait_stat(input logic [3:0] mask);
      logic [7:0] rd;
      int         tries;
      tries = 0;
      read_reg(slot_addr(regx_pkg::RA_STAT), rd);
      while (rd !== {4'h0, mask} && tries < 6) begin
         read_reg(slot_addr(regx_pkg::RA_STAT), rd);
         tries++;
      end
      if (rd !== {4'h0, mask}) timeout_stop("debounced STAT value");
   endtask

   task automatic check_stat_bit(input int bit_i, inout logic [3:0] mask);
      logic [3:0] bit_m;
      bit_m = 4'b0001 << bit_i;
      i_di_stat = i_di_stat | bit_m; // One-cycle glitch
      @(posedge clk);
      #1;
      i_di_stat = i_di_stat & ~bit_m;
      clear_table();
      for (int n = 0; n < 8; n++) begin // STAT sampled on every cycle after the glitch
         add_rd(slot_addr(regx_pkg::RA_STAT), {4'h0, mask}, 1'b0);
      end
      run_table();
      i_di_stat = i_di_stat | bit_m;
      mask = mask | bit_m;
      wait_stat(mask);
   endtask

   // ==========================================================
   // Main sequence
   // ==========================================================
   initial begin : main
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] d0;
      logic [7:0] nv;
      logic [7:0] lo;
      logic [7:0] hi;
      logic [7:0] w;
      logic [4:0] v;
      logic [3:0] mask;
      clk        = 1'b0;
      aswk_clrz  = 1'b0;
      i_cmd_stb  = 1'b0;
      i_cmd_op   = regx_pkg::XOP_IDLE;
      i_cmd_addr = 8'h00;
      i_cmd_wdat = 8'h00;
      i_di_stat  = 4'h0;
      i_aswclk   = 1'b0;
      i_di_aswk  = 5'h00;
      seed       = 14;
      repeat (16) @(posedge clk);
      #1;
      aswk_clrz = 1'b1;

      check_bit("o_rsp_stb after reset", o_rsp_stb, 1'b0);
      check_bit("o_rsp_miss after reset", o_rsp_miss, 1'b0);
      check_bit("o_pwm after reset", o_pwm, 1'b0);
      check_bit("o_bkpt_ena after reset", o_bkpt_ena, 1'b0);
      check_pc("o_bkpt_pc after reset", o_bkpt_pc, 15'h0000);
      check_byte("o_nvm_ctl after reset", {2'b00, o_nvm_ctl}, {2'b00, NVM_RST[7:2]});

      // Local registers from reset values through random write and read back
      b0 = rand_byte();
      b1 = rand_byte();
      d0 = rand_byte();
      nv = rand_byte();
      clear_table();
      add_rd(slot_addr(regx_pkg::RA_BCK0), 8'h00, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_BCK1), 8'h00, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_DMY0), 8'h00, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_NVMCTL), NVM_RST, 1'b0);
      add_wr(slot_addr(regx_pkg::RA_BCK0), b0);
      add_wr(slot_addr(regx_pkg::RA_BCK1), b1);
      add_wr(slot_addr(regx_pkg::RA_DMY0), d0);
      add_wr(slot_addr(regx_pkg::RA_NVMCTL), nv);
      add_rd(slot_addr(regx_pkg::RA_BCK0), b0, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_BCK1), b1, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_DMY0), d0, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_NVMCTL), nv & 8'hFC, 1'b0);
      run_table();
      check_byte("o_bck0", o_bck0, b0);
      check_byte("o_bck1", o_bck1, b1);
      check_byte("o_dmy0", o_dmy0, d0);
      check_byte("o_nvm_ctl", {2'b00, o_nvm_ctl}, {2'b00, nv[7:2]});

      // Unimplemented slots and misses issued back to back
      clear_table();
      add_wr(8'h82, rand_byte());
      add_rd(8'h82, `REGX_UNIMPL_RD, 1'b0);
      add_rd(8'hFF, `REGX_UNIMPL_RD, 1'b0);
      add_rd(8'hA0, `REGX_UNIMPL_RD, 1'b0);
      add_rd(8'h10, 8'h00, 1'b1);
      add_wr(8'h04, rand_byte()); // Missed write aliasing BCK0
      add_rd(8'h7F, 8'h00, 1'b1);
      add_rd(8'h84, b0, 1'b0);
      add_rd(8'h00, 8'h00, 1'b1);
      run_table();

      // Breakpoint commits only on the high byte
      lo = rand_byte();
      hi = rand_byte() | 8'h80;
      clear_table();
      add_wr(slot_addr(regx_pkg::RA_BPPCL), lo);
      add_rd(slot_addr(regx_pkg::RA_BPPCL), 8'h00, 1'b0);
      run_table();
      check_pc("o_bkpt_pc after BPPCL only", o_bkpt_pc, 15'h0000);
      check_bit("o_bkpt_ena after BPPCL only", o_bkpt_ena, 1'b0);
      clear_table();
      add_wr(slot_addr(regx_pkg::RA_BPPCH), hi);
      add_rd(slot_addr(regx_pkg::RA_BPPCL), lo, 1'b0);
      add_rd(slot_addr(regx_pkg::RA_BPPCH), hi, 1'b0);
      run_table();
      check_pc("o_bkpt_pc after BPPCH", o_bkpt_pc, {hi[6:0], lo});
      check_bit("o_bkpt_ena after BPPCH", o_bkpt_ena, hi[7]);

      // Compare below and above the period
      check_pwm(rand_byte() & 8'h0F, 8'h10 | (rand_byte() & 8'h07));
      check_pwm(8'h18 | (rand_byte() & 8'h07), rand_byte() & 8'h0F);

      mask = 4'h0;
      for (int i = 0; i < 4; i++) begin
         check_stat_bit(i, mask);
      end
      i_di_stat = 4'h0;
      wait_stat(4'h0);

      // Wake latch capture followed by the clear code
      b0 = rand_byte();
      v  = b0[4:0];
      i_di_aswk = v;
      #3;
      i_aswclk = 1'b1;
      #4;
      i_aswclk = 1'b0;
      @(posedge clk);
      #1;
      w = rand_byte();
      if (w == `REGX_WAKE_CLR) w = 8'h3C;
      clear_table();
      add_rd(slot_addr(regx_pkg::RA_WAKE), {2'b00, 1'b1, v}, 1'b0);
      add_wr(slot_addr(regx_pkg::RA_WAKE), w);
      add_rd(slot_addr(regx_pkg::RA_WAKE), {2'b00, 1'b1, v}, 1'b0);
      add_wr(slot_addr(regx_pkg::RA_WAKE), `REGX_WAKE_CLR);
      add_rd(slot_addr(regx_pkg::RA_WAKE), 8'h00, 1'b0);
      run_table();

      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+.
regx_pkg.sv
dbnc.sv
xdata_dec.sv
regx.sv
pwm_gen.sv
regx_top.sv
tb_regx_top.sv

// ==== Makefile ====
# Verilator flow for the register block

VERILATOR ?= verilator
TOP       ?= tb_regx_top
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
